// ==== sources.f ====
+incdir+common
common/rv64_pkg.sv
decode/ContrGen.sv
decode/ImmGen.sv
execute/Alu.sv
execute/BranchUnit.sv
execute/WriteBack.sv
source/RegFile.sv
source/ExecCore.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbTop.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module tbTop -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;

    localparam int perTest  = 400;
    localparam int numTests = 5;
    localparam int maxCycles = perTest * numTests + 1000; // reset and slack on top

    // {mask of fixed bits, fixed bits}, grouped by test
    localparam logic [63:0] instrTab [51] = '{
        64'h0000707F_00000013, 64'h0000707F_00003013, 64'h0000707F_00004013,
        64'h0000707F_00007013, 64'hFC00707F_00001013, 64'hFC00707F_00005013,
        64'hFE00707F_40005013, 64'hFE00707F_00000033, 64'hFE00707F_40000033,
        64'hFE00707F_00007033, 64'hFE00707F_00006033, 64'hFE00707F_00002033,
        64'hFE00707F_00003033,
        64'hFE00707F_0000003B, 64'hFE00707F_4000003B, 64'hFE00707F_0000103B,
        64'hFE00707F_4000503B, 64'hFE00707F_0200003B, 64'hFE00707F_0200403B,
        64'hFE00707F_0200603B, 64'h0000707F_0000001B, 64'hFE00707F_0000101B,
        64'hFE00707F_4000501B, 64'hFFFFF07F_FFF00013, 64'hFFFFF07F_80000037,
        64'hFFFFF07F_00000013,
        64'h0000707F_00003003, 64'h0000707F_00002003, 64'h0000707F_00006003,
        64'h0000707F_00001003, 64'h0000707F_00005003, 64'h0000707F_00004003,
        64'h0000707F_00003023, 64'h0000707F_00002023, 64'h0000707F_00001023,
        64'h0000707F_00000023,
        64'h0000007F_00000037, 64'h0000007F_00000017, 64'h0000007F_0000006F,
        64'h0000707F_00000067, 64'h0000707F_00000063, 64'h0000707F_00001063,
        64'h0000707F_00005063, 64'h0000707F_00004063, 64'h0000707F_00006063,
        64'h0000007F_00000007, 64'h0000007F_0000000F, 64'h0000007F_0000002F,
        64'h0000007F_00000073, 64'h0000007F_00000053, 64'h0000007F_00000027
    };
    localparam int groupBase [5] = '{0, 13, 26, 36, 45};
    localparam int groupSize [5] = '{13, 13, 10, 9, 6};

    logic               clk;
    logic               rstN;
    logic [31:0]        instr;
    logic [63:0]        pc;
    logic [63:0]        memRdata;
    logic [63:0]        nextPc;
    logic               memWr;
    logic [63:0]        memAddr;
    logic [63:0]        memWdata;
    rv64Pkg::memOpT     memOp;
    logic               wbEn;
    logic [4:0]         wbAddr;
    logic [63:0]        wbData;
    logic               illegalInst;
    logic               checkEn;
    logic [2:0]         testId;
    logic               done;
    int                 failCount;
    int                 cycles;

    tbClock clockGen (.clk(clk), .rstN(rstN));

    ExecCore dut (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .memRdata(memRdata),
        .nextPc(nextPc), .memWr(memWr), .memAddr(memAddr), .memWdata(memWdata),
        .memOp(memOp), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .illegalInst(illegalInst)
    );

    tbChecker scoreboard (
        .clk(clk), .rstN(rstN), .checkEn(checkEn), .testId(testId), .instr(instr),
        .pc(pc), .memRdata(memRdata), .nextPc(nextPc), .memWr(memWr),
        .memAddr(memAddr), .memWdata(memWdata), .memOp(memOp), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .illegalInst(illegalInst),
        .done(done), .failCount(failCount)
    );

    // word and branch groups use x0..x7 so edge values get reused
    function automatic logic [31:0] pickInstr(input int grp);
        logic [63:0] e;
        logic [31:0] w;
        e = instrTab[groupBase[grp] + int'($urandom % groupSize[grp])];
        w = $urandom;
        if (grp == 1 || grp == 3) begin
            w = w & ~32'h018C0C00;
        end
        return (w & ~e[63:32]) | e[31:0];
    endfunction

    initial begin
        instr    = '0;
        pc       = '0;
        memRdata = '0;
        checkEn  = 1'b0;
        testId   = '0;
        wait (rstN === 1'b1);
        void'($urandom(32'h13a7470c));
        for (int t = 0; t < numTests; t++) begin
            for (int i = 0; i < perTest; i++) begin
                @(posedge clk);
                instr    <= pickInstr(t);
                pc       <= {$urandom, $urandom} & ~64'h3;
                memRdata <= {$urandom, $urandom};
                testId   <= 3'(t);
                checkEn  <= 1'b1;
            end
        end
        @(posedge clk);
        checkEn <= 1'b0;
        wait (done === 1'b1);
        if (failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("timeout: the checker did not finish within %0d cycles", maxCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

// ==== testbench/tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
    input  logic           clk,
    input  logic           rstN,
    input  logic           checkEn,
    input  logic [2:0]     testId,
    input  logic [31:0]    instr,
    input  logic [63:0]    pc,
    input  logic [63:0]    memRdata,
    input  logic [63:0]    nextPc,
    input  logic           memWr,
    input  logic [63:0]    memAddr,
    input  logic [63:0]    memWdata,
    input  rv64Pkg::memOpT memOp,
    input  logic           wbEn,
    input  logic [4:0]     wbAddr,
    input  logic [63:0]    wbData,
    input  logic           illegalInst,
    output logic           done,
    output int             failCount
);

    string       names [5] = '{"alu and regs", "word ops", "memory", "control flow", "illegal"};
    logic [63:0] shadow [32];
    logic        eIll;
    logic        eWb;
    logic        eMemWr;
    logic        eAddrChk;
    logic [2:0]  eMemOp;
    logic [63:0] eData;
    logic [63:0] eAddr;
    logic [63:0] eNext;
    int          cnt;
    int          testErr;
    int          passCount;

    function automatic logic [63:0] sx32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    task automatic expectEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got %h expected %h (instr %h)",
                     $time, name, got, exp, instr);
            testErr++;
        end
    endtask

    task automatic predict();
        logic [6:0]         op;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [63:0]        a;
        logic [63:0]        b;
        logic [63:0]        iI;
        logic [63:0]        iS;
        logic [63:0]        iB;
        logic [63:0]        iU;
        logic [63:0]        iJ;
        logic signed [31:0] x;
        logic signed [31:0] y;
        logic               tk;
        op = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        a  = shadow[instr[19:15]];
        b  = shadow[instr[24:20]];
        iI = {{52{instr[31]}}, instr[31:20]};
        iS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
        iB = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        iU = {{32{instr[31]}}, instr[31:12], 12'b0};
        iJ = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        x  = a[31:0];
        y  = b[31:0];
        tk = 1'b0;
        eIll = 1'b0;
        eWb = 1'b0;
        eMemWr = 1'b0;
        eAddrChk = 1'b0;
        eMemOp = 3'd0;
        eData = '0;
        eAddr = '0;
        eNext = pc + 64'd4;
        case (op)
            7'h13: begin
                eWb = 1'b1;
                case (f3)
                    3'b000: eData = a + iI;
                    3'b011: eData = {63'b0, a < iI};
                    3'b100: eData = a ^ iI;
                    3'b111: eData = a & iI;
                    3'b001: if (f7[6:1] == 6'd0) eData = a << instr[25:20]; else eIll = 1'b1;
                    3'b101: begin
                        if (f7[6:1] == 6'd0) eData = a >> instr[25:20];
                        else if (f7 == 7'h20) eData = $signed(a) >>> instr[25:20];
                        else eIll = 1'b1;
                    end
                    default: eIll = 1'b1;
                endcase
            end
            7'h33: begin
                eWb = 1'b1;
                case ({f7, f3})
                    10'b0000000_000: eData = a + b;
                    10'b0100000_000: eData = a - b;
                    10'b0000000_111: eData = a & b;
                    10'b0000000_110: eData = a | b;
                    10'b0000000_010: eData = {63'b0, $signed(a) < $signed(b)};
                    10'b0000000_011: eData = {63'b0, a < b};
                    default:         eIll = 1'b1;
                endcase
            end
            7'h3B: begin
                eWb = 1'b1;
                case ({f7, f3})
                    10'b0000000_000: eData = sx32(x + y);
                    10'b0100000_000: eData = sx32(x - y);
                    10'b0000000_001: eData = sx32(x << y[4:0]);
                    10'b0100000_101: eData = sx32(x >>> y[4:0]);
                    10'b0000001_000: eData = sx32(x * y);
                    10'b0000001_100: begin
                        if (y == 32'd0) eData = '1;
                        else if (x == 32'h80000000 && y == 32'hFFFFFFFF) eData = sx32(x);
                        else eData = sx32(x / y);
                    end
                    10'b0000001_110: begin
                        if (y == 32'd0) eData = sx32(x);
                        else if (x == 32'h80000000 && y == 32'hFFFFFFFF) eData = '0;
                        else eData = sx32(x % y);
                    end
                    default: eIll = 1'b1;
                endcase
            end
            7'h1B: begin
                eWb = 1'b1;
                if (f3 == 3'b000) eData = sx32(x + iI[31:0]);
                else if (f3 == 3'b001 && f7[6:1] == 6'd0) eData = sx32(x << instr[24:20]);
                else if (f3 == 3'b101 && f7 == 7'h20) eData = sx32(x >>> instr[24:20]);
                else eIll = 1'b1;
            end
            7'h03: begin
                eWb = 1'b1;
                eAddrChk = 1'b1;
                eAddr = a + iI;
                case (f3)
                    3'b001: {eMemOp, eData} = {3'd6, {{48{memRdata[15]}}, memRdata[15:0]}};
                    3'b010: {eMemOp, eData} = {3'd5, sx32(memRdata[31:0])};
                    3'b011: {eMemOp, eData} = {3'd4, memRdata};
                    3'b100: {eMemOp, eData} = {3'd3, {56'b0, memRdata[7:0]}};
                    3'b101: {eMemOp, eData} = {3'd2, {48'b0, memRdata[15:0]}};
                    3'b110: {eMemOp, eData} = {3'd1, {32'b0, memRdata[31:0]}};
                    default: eIll = 1'b1;
                endcase
            end
            7'h23: begin
                eIll = f3[2];
                eMemWr = 1'b1;
                eAddrChk = 1'b1;
                eAddr = a + iS;
                eMemOp = (f3 == 3'd3) ? 3'd4 : 3'd3 - f3; // sb 3, sh 2, sw 1, sd 4
            end
            7'h37: {eWb, eData} = {1'b1, iU};
            7'h17: {eWb, eData} = {1'b1, pc + iU};
            7'h6F: begin
                {eWb, eData} = {1'b1, pc + 64'd4};
                eNext = pc + iJ;
            end
            7'h67: begin
                eIll = (f3 != 3'b000);
                {eWb, eData} = {1'b1, pc + 64'd4};
                eNext = (a + iI) & ~64'h1;
            end
            7'h63: begin
                case (f3)
                    3'b000:  tk = (a == b);
                    3'b001:  tk = (a != b);
                    3'b100:  tk = ($signed(a) < $signed(b));
                    3'b101:  tk = ($signed(a) >= $signed(b));
                    3'b110:  tk = (a < b);
                    default: eIll = 1'b1;
                endcase
                if (tk) eNext = pc + iB;
            end
            default: eIll = 1'b1;
        endcase
        if (eIll) begin // illegal words change nothing
            {eWb, eMemWr, eAddrChk, eMemOp} = '0;
            eNext = pc + 64'd4;
        end
    endtask

    initial begin
        done = 1'b0;
        failCount = 0;
        passCount = 0;
        cnt = 0;
        testErr = 0;
    end

    always @(negedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) shadow[i] = '0;
        end else if (checkEn) begin
            predict();
            expectEq("illegalInst", 64'(illegalInst), 64'(eIll));
            expectEq("wbEn", 64'(wbEn), 64'(eWb));
            expectEq("memWr", 64'(memWr), 64'(eMemWr));
            expectEq("memOp", 64'(memOp), 64'(eMemOp));
            expectEq("nextPc", nextPc, eNext);
            if (eWb) begin
                expectEq("wbAddr", 64'(wbAddr), 64'(instr[11:7]));
                expectEq("wbData", wbData, eData);
                if (instr[11:7] != 5'd0) shadow[instr[11:7]] = eData;
            end
            if (eAddrChk) expectEq("memAddr", memAddr, eAddr);
            if (eMemWr) expectEq("memWdata", memWdata, shadow[instr[24:20]]);
            cnt++;
            if (cnt == 400) begin
                $display("test %0d %s: %0d instructions, %0d errors",
                         testId, names[testId], cnt, testErr);
                if (testErr == 0) passCount++;
                else failCount++;
                cnt = 0;
                testErr = 0;
                if (testId == 3'd4) begin
                    $display("tests passed %0d, failed %0d", passCount, failCount);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
    end

    always #4 clk = ~clk; // 8 ns period

endmodule

// ==== source/ExecCore.sv ====
`timescale 1ns/1ps

module ExecCore (
    input  logic            clk,
    input  logic            rstN,
    input  rv64Pkg::instT   instr,
    input  rv64Pkg::xlenT   pc,
    input  rv64Pkg::xlenT   memRdata,
    output rv64Pkg::xlenT   nextPc,
    output logic            memWr,
    output rv64Pkg::xlenT   memAddr,
    output rv64Pkg::xlenT   memWdata,
    output rv64Pkg::memOpT  memOp,
    output logic            wbEn,
    output rv64Pkg::regIdxT wbAddr,
    output rv64Pkg::xlenT   wbData,
    output logic            illegalInst
);

    rv64Pkg::aluCtT   aluCt;
    rv64Pkg::extOpT   extOp;
    rv64Pkg::aluBSrcT aluBSrc;
    rv64Pkg::branchT  branch;
    logic             regWr;
    logic             aluASrc;
    logic             memWrCtl;
    logic             memToReg;
    logic             isTruncate;
    logic             isSext;
    rv64Pkg::xlenT    imm;
    rv64Pkg::xlenT    rs1Data;
    rv64Pkg::xlenT    rs2Data;
    rv64Pkg::xlenT    aluResult;
    logic             zero;
    logic             less;

    ContrGen uContrGen (
        .opcode     (instr[6:0]),
        .func3      (instr[14:12]),
        .func7      (instr[31:25]),
        .aluCt      (aluCt),
        .extOp      (extOp),
        .regWr      (regWr),
        .aluASrc    (aluASrc),
        .aluBSrc    (aluBSrc),
        .branch     (branch),
        .memWr      (memWrCtl),
        .memOp      (memOp),
        .memToReg   (memToReg),
        .isTruncate (isTruncate),
        .isSext     (isSext),
        .illegalInst(illegalInst)
    );

    ImmGen uImmGen (
        .instr(instr),
        .extOp(extOp),
        .imm  (imm)
    );

    RegFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs1Addr(instr[19:15]),
        .rs2Addr(instr[24:20]),
        .wrEn   (wbEn),
        .wrAddr (wbAddr),
        .wrData (wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    Alu uAlu (
        .aluCt     (aluCt),
        .aluASrc   (aluASrc),
        .aluBSrc   (aluBSrc),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .isTruncate(isTruncate),
        .isSext    (isSext),
        .result    (aluResult),
        .zero      (zero),
        .less      (less)
    );

    BranchUnit uBranchUnit (
        .branch (branch),
        .pc     (pc),
        .imm    (imm),
        .rs1Data(rs1Data),
        .zero   (zero),
        .less   (less),
        .nextPc (nextPc)
    );

    WriteBack uWriteBack (
        .memToReg (memToReg),
        .memOp    (memOp),
        .aluResult(aluResult),
        .memRdata (memRdata),
        .wbData   (wbData)
    );

    assign wbEn     = regWr && rstN;
    assign wbAddr   = instr[11:7];
    assign memWr    = memWrCtl && rstN;
    assign memAddr  = aluResult;  // rs1 + imm for loads and stores
    assign memWdata = rs2Data;    // memory side aligns lanes

    illegalIsQuiet: assert property (
        @(posedge clk) disable iff (!rstN)
        illegalInst |-> (!wbEn && !memWr)
    );

endmodule

// ==== source/RegFile.sv ====
`timescale 1ns/1ps
`include "rv64_config.svh"

module RegFile (
    input  logic            clk,
    input  logic            rstN,
    input  rv64Pkg::regIdxT rs1Addr,
    input  rv64Pkg::regIdxT rs2Addr,
    input  logic            wrEn,
    input  rv64Pkg::regIdxT wrAddr,
    input  rv64Pkg::xlenT   wrData,
    output rv64Pkg::xlenT   rs1Data,
    output rv64Pkg::xlenT   rs2Data
);

    rv64Pkg::xlenT regs [`NREGS];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 reads zero whatever is stored
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    x0StaysZero: assert property (
        @(posedge clk) disable iff (!rstN)
        wrEn |=> (regs[0] == '0)
    );

endmodule

// ==== execute/WriteBack.sv ====
`timescale 1ns/1ps
`include "rv64_config.svh"

module WriteBack (
    input  logic           memToReg,
    input  rv64Pkg::memOpT memOp,
    input  rv64Pkg::xlenT  aluResult,
    input  rv64Pkg::xlenT  memRdata,
    output rv64Pkg::xlenT  wbData
);

    rv64Pkg::xlenT loadVal;

    // memRdata arrives lane aligned at bit 0
    always_comb begin
        case (memOp)
            rv64Pkg::memWord:  loadVal = {{(`XLEN-32){memRdata[31]}}, memRdata[31:0]};
            rv64Pkg::memWordU: loadVal = {{(`XLEN-32){1'b0}}, memRdata[31:0]};
            rv64Pkg::memHalf:  loadVal = {{(`XLEN-16){memRdata[15]}}, memRdata[15:0]};
            rv64Pkg::memHalfU: loadVal = {{(`XLEN-16){1'b0}}, memRdata[15:0]};
            rv64Pkg::memByteU: loadVal = {{(`XLEN-8){1'b0}}, memRdata[7:0]};
            default:           loadVal = memRdata; // ld
        endcase
    end

    assign wbData = memToReg ? loadVal : aluResult;

endmodule

// ==== execute/BranchUnit.sv ====
`timescale 1ns/1ps

module BranchUnit (
    input  rv64Pkg::branchT branch,
    input  rv64Pkg::xlenT   pc,
    input  rv64Pkg::xlenT   imm,
    input  rv64Pkg::xlenT   rs1Data,
    input  logic            zero,
    input  logic            less,
    output rv64Pkg::xlenT   nextPc
);

    rv64Pkg::xlenT target;
    rv64Pkg::xlenT seqPc;
    rv64Pkg::xlenT regTarget;

    assign target    = pc + imm;
    assign seqPc     = pc + rv64Pkg::xlenT'(4);
    assign regTarget = (rs1Data + imm) & ~rv64Pkg::xlenT'(1); // jalr drops bit 0

    always_comb begin
        case (branch)
            rv64Pkg::brJal:  nextPc = target;
            rv64Pkg::brJalr: nextPc = regTarget;
            rv64Pkg::brEq:   nextPc = zero ? target : seqPc;
            rv64Pkg::brNe:   nextPc = zero ? seqPc : target;
            rv64Pkg::brGe:   nextPc = less ? seqPc : target;
            rv64Pkg::brLt:   nextPc = less ? target : seqPc;
            default:         nextPc = seqPc;
        endcase
    end

endmodule

// ==== execute/Alu.sv ====
`timescale 1ns/1ps
`include "rv64_config.svh"

module Alu (
    input  rv64Pkg::aluCtT   aluCt,
    input  logic             aluASrc,
    input  rv64Pkg::aluBSrcT aluBSrc,
    input  rv64Pkg::xlenT    pc,
    input  rv64Pkg::xlenT    rs1Data,
    input  rv64Pkg::xlenT    rs2Data,
    input  rv64Pkg::xlenT    imm,
    input  logic             isTruncate,
    input  logic             isSext,
    output rv64Pkg::xlenT    result,
    output logic             zero,
    output logic             less
);

    localparam int shW = $clog2(`XLEN);

    rv64Pkg::xlenT           opA;
    rv64Pkg::xlenT           opB;
    rv64Pkg::xlenT           a;
    rv64Pkg::xlenT           b;
    rv64Pkg::xlenT           diff;
    rv64Pkg::xlenT           raw;
    logic                    borrow;
    logic [shW-1:0]          shamt;
    logic                    divZero;
    logic                    divOvf;
    logic signed [`XLEN-1:0] quot;
    logic signed [`XLEN-1:0] remd;

    always_comb begin
        opA = aluASrc ? rs1Data : pc;
        case (aluBSrc)
            rv64Pkg::bImm: opB = imm;
            rv64Pkg::bRs2: opB = rs2Data;
            default:       opB = rv64Pkg::xlenT'(4);
        endcase
    end

    // word forms see sign-extended low halves
    assign a     = isTruncate ? {{(`XLEN-32){opA[31]}}, opA[31:0]} : opA;
    assign b     = isTruncate ? {{(`XLEN-32){opB[31]}}, opB[31:0]} : opB;
    assign shamt = isTruncate ? {1'b0, b[4:0]} : b[shW-1:0];

    assign {borrow, diff} = {1'b0, a} - {1'b0, b};
    assign zero = (diff == '0);
    assign less = (aluCt == rv64Pkg::aluSltu) ? borrow :
                  (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN-1];

    assign divZero = (b == '0);
    assign divOvf  = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
    assign quot    = $signed(a) / $signed(b);
    assign remd    = $signed(a) % $signed(b);

    always_comb begin
        case (aluCt)
            rv64Pkg::aluAdd:  raw = a + b;
            rv64Pkg::aluSllB: raw = aluASrc ? (a << shamt) : b; // lui takes B
            rv64Pkg::aluSlt,
            rv64Pkg::aluSltu: raw = rv64Pkg::xlenT'(less);
            rv64Pkg::aluXor:  raw = a ^ b;
            rv64Pkg::aluSrl:  raw = a >> shamt;
            rv64Pkg::aluOr:   raw = a | b;
            rv64Pkg::aluAnd:  raw = a & b;
            rv64Pkg::aluSub:  raw = diff;
            rv64Pkg::aluSra:  raw = $signed(a) >>> shamt;
            rv64Pkg::aluMul:  raw = a * b;
            rv64Pkg::aluDiv:  raw = divZero ? '1 : (divOvf ? a : quot);
            rv64Pkg::aluRem:  raw = divZero ? a : (divOvf ? '0 : remd);
            default:          raw = b;
        endcase
    end

    assign result = isSext ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== decode/ImmGen.sv ====
`timescale 1ns/1ps
`include "rv64_config.svh"

module ImmGen (
    input  rv64Pkg::instT  instr,
    input  rv64Pkg::extOpT extOp,
    output rv64Pkg::xlenT  imm
);

    // shift immediates keep funct7 in imm[11:5], the ALU only looks at the shamt bits
    always_comb begin
        case (extOp)
            rv64Pkg::extI: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            rv64Pkg::extS: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv64Pkg::extB: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv64Pkg::extU: begin
                imm = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            end
            rv64Pkg::extJ: begin
                imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // none and R format
            end
        endcase
    end

endmodule

// ==== decode/ContrGen.sv ====
`timescale 1ns/1ps

module ContrGen (
    input  logic [6:0]       opcode,
    input  logic [2:0]       func3,
    input  logic [6:0]       func7,
    output rv64Pkg::aluCtT   aluCt,
    output rv64Pkg::extOpT   extOp,
    output logic             regWr,
    output logic             aluASrc,
    output rv64Pkg::aluBSrcT aluBSrc,
    output rv64Pkg::branchT  branch,
    output logic             memWr,
    output rv64Pkg::memOpT   memOp,
    output logic             memToReg,
    output logic             isTruncate,
    output logic             isSext,
    output logic             illegalInst
);

    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opRegW   = 7'b0111011;
    localparam logic [6:0] opImmW   = 7'b0011011;

    rv64Pkg::extOpT fmt;
    logic           isWord;
    logic           pcBased;

    always_comb begin
        case (opcode)
            opImm, opLoad, opJalr, opImmW: fmt = rv64Pkg::extI;
            opReg, opRegW:                 fmt = rv64Pkg::extR;
            opAuipc, opLui:                fmt = rv64Pkg::extU;
            opJal:                         fmt = rv64Pkg::extJ;
            opStore:                       fmt = rv64Pkg::extS;
            opBranch:                      fmt = rv64Pkg::extB;
            default:                       fmt = rv64Pkg::extNone;
        endcase
    end

    always_comb begin
        illegalInst = 1'b0;
        casez ({func7, func3, opcode})
            17'bzzzzzzz_000_0010011, // addi
            17'bzzzzzzz_zzz_0010111, // auipc
            17'bzzzzzzz_zzz_1101111, // jal, link pc+4
            17'bzzzzzzz_000_1100111, // jalr
            17'bzzzzzzz_0zz_0100011, // sb sh sw sd
            17'bzzzzzzz_01z_0000011, // lw ld
            17'bzzzzzzz_001_0000011, // lh
            17'bzzzzzzz_1zz_0000011, // lbu lhu lwu, 111 caught below
            17'b0000000_000_0110011, // add
            17'b0000000_000_0111011, // addw
            17'bzzzzzzz_000_0011011: aluCt = rv64Pkg::aluAdd; // addiw
            17'b0100000_000_0110011, // sub
            17'b0100000_000_0111011, // subw
            17'bzzzzzzz_00z_1100011: aluCt = rv64Pkg::aluSub; // beq bne
            17'bzzzzzzz_zzz_0110111, // lui passes imm
            17'b000000z_001_0010011, // slli
            17'b000000z_001_0011011, // slliw
            17'b0000000_001_0111011: aluCt = rv64Pkg::aluSllB; // sllw
            17'b0000000_010_0110011, // slt
            17'bzzzzzzz_10z_1100011: aluCt = rv64Pkg::aluSlt; // blt bge
            17'bzzzzzzz_011_0010011, // sltiu
            17'b0000000_011_0110011, // sltu
            17'bzzzzzzz_110_1100011: aluCt = rv64Pkg::aluSltu; // bltu
            17'bzzzzzzz_100_0010011: aluCt = rv64Pkg::aluXor; // xori
            17'b000000z_101_0010011: aluCt = rv64Pkg::aluSrl; // srli
            17'b0000000_110_0110011: aluCt = rv64Pkg::aluOr;
            17'bzzzzzzz_111_0010011, // andi
            17'b0000000_111_0110011: aluCt = rv64Pkg::aluAnd;
            17'b0100000_101_0010011, // srai
            17'b0100000_101_0011011, // sraiw
            17'b0100000_101_0111011: aluCt = rv64Pkg::aluSra; // sraw
            17'b0000001_000_0111011: aluCt = rv64Pkg::aluMul; // mulw
            17'b0000001_100_0111011: aluCt = rv64Pkg::aluDiv; // divw
            17'b0000001_110_0111011: aluCt = rv64Pkg::aluRem; // remw
            default: begin
                aluCt       = rv64Pkg::aluSllB;
                illegalInst = 1'b1;
            end
        endcase
        if (opcode == opLoad && func3 == 3'b111) begin
            aluCt       = rv64Pkg::aluSllB;
            illegalInst = 1'b1;
        end
    end

    assign isWord  = (opcode == opRegW) || (opcode == opImmW);
    assign pcBased = (opcode == opAuipc) || (opcode == opLui) ||
                     (opcode == opJal) || (opcode == opJalr);

    assign extOp      = illegalInst ? rv64Pkg::extNone : fmt;
    assign regWr      = (extOp == rv64Pkg::extR) || (extOp == rv64Pkg::extI) ||
                        (extOp == rv64Pkg::extU) || (extOp == rv64Pkg::extJ);
    assign aluASrc    = !illegalInst && !pcBased;
    assign memWr      = !illegalInst && (opcode == opStore);
    assign memToReg   = !illegalInst && (opcode == opLoad);
    assign isTruncate = !illegalInst && isWord;
    assign isSext     = !illegalInst && isWord;

    always_comb begin
        if (extOp == rv64Pkg::extR || extOp == rv64Pkg::extB) begin
            aluBSrc = rv64Pkg::bRs2;
        end else if (!illegalInst && (opcode == opJal || opcode == opJalr)) begin
            aluBSrc = rv64Pkg::bFour; // link value
        end else begin
            aluBSrc = rv64Pkg::bImm;
        end
    end

    always_comb begin
        branch = rv64Pkg::brNone;
        if (!illegalInst && opcode == opJal) begin
            branch = rv64Pkg::brJal;
        end else if (!illegalInst && opcode == opJalr) begin
            branch = rv64Pkg::brJalr;
        end else if (!illegalInst && opcode == opBranch) begin
            case (func3)
                3'b000:         branch = rv64Pkg::brEq;
                3'b001:         branch = rv64Pkg::brNe;
                3'b101:         branch = rv64Pkg::brGe;
                3'b100, 3'b110: branch = rv64Pkg::brLt; // bltu via unsigned less
                default:        branch = rv64Pkg::brNone;
            endcase
        end
    end

    always_comb begin
        memOp = rv64Pkg::memNone;
        if (memToReg) begin
            case (func3)
                3'b001:  memOp = rv64Pkg::memHalf;
                3'b010:  memOp = rv64Pkg::memWord;
                3'b011:  memOp = rv64Pkg::memDouble;
                3'b100:  memOp = rv64Pkg::memByteU;
                3'b101:  memOp = rv64Pkg::memHalfU;
                default: memOp = rv64Pkg::memWordU; // lwu
            endcase
        end else if (memWr) begin
            case (func3)
                3'b000:  memOp = rv64Pkg::memByteU;
                3'b001:  memOp = rv64Pkg::memHalfU;
                3'b010:  memOp = rv64Pkg::memWordU;
                default: memOp = rv64Pkg::memDouble;
            endcase
        end
    end

endmodule

// ==== common/rv64_pkg.sv ====
`include "rv64_config.svh"

package rv64Pkg;

    typedef logic [`XLEN-1:0] xlenT;
    typedef logic [`ILEN-1:0] instT;
    typedef logic [`REGW-1:0] regIdxT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSllB = 4'b0001, // shift left, or pass B when A is the pc
        aluSlt  = 4'b0010,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSltu = 4'b1010,
        aluRem  = 4'b1100,
        aluSra  = 4'b1101,
        aluMul  = 4'b1110,
        aluDiv  = 4'b1111
    } aluCtT;

    typedef enum logic [2:0] {
        extNone = 3'd0,
        extR    = 3'd1,
        extI    = 3'd2,
        extS    = 3'd3,
        extB    = 3'd4,
        extU    = 3'd5,
        extJ    = 3'd6
    } extOpT;

    typedef enum logic [1:0] {
        bImm  = 2'd0,
        bRs2  = 2'd1,
        bFour = 2'd2
    } aluBSrcT;

    typedef enum logic [2:0] {
        brNone = 3'd0,
        brJal  = 3'd1,
        brJalr = 3'd2,
        brEq   = 3'd4,
        brNe   = 3'd5,
        brGe   = 3'd6,
        brLt   = 3'd7
    } branchT;

    // store widths reuse the unsigned codes
    typedef enum logic [2:0] {
        memNone   = 3'b000,
        memWordU  = 3'b001,
        memHalfU  = 3'b010,
        memByteU  = 3'b011,
        memDouble = 3'b100,
        memWord   = 3'b101,
        memHalf   = 3'b110
    } memOpT;

endpackage

// ==== common/rv64_config.svh ====
`ifndef RV64_CONFIG_SVH
`define RV64_CONFIG_SVH

// data path width
`define XLEN 64

// instruction word width
`define ILEN 32

// architectural registers
`define NREGS 32

// register index width
`define REGW 5

`endif
